// File: hdl/crc_ahb_cfg.svh
// CRC accelerator configuration
// Register word offsets on the AHB slave, reset values of the
// programmable registers and depth of the data write buffer
`ifndef CRC_AHB_CFG_SVH
`define CRC_AHB_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Register map, word offsets taken from HADDR[4:2]
////////////////////////////////////////////////////////////////////////////
`define CRC_DR_OFS    3'h0
`define CRC_IDR_OFS   3'h1
`define CRC_CR_OFS    3'h2
`define CRC_INIT_OFS  3'h4
`define CRC_POL_OFS   3'h5

////////////////////////////////////////////////////////////////////////////
// Reset values
////////////////////////////////////////////////////////////////////////////
`define CRC_INIT_RST  32'hFFFF_FFFF
`define CRC_POL_RST   32'h04C1_1DB7
// Control register fields {rev_out, rev_in, poly_size}
`define CRC_CR_RST    5'h00

// Number of data writes queued ahead of the engine
`define CRC_BUF_DEPTH 2

`endif

// File: hdl/crc_ahb_pkg.sv
// CRC accelerator shared types
// Bus and CRC words, width and reversal encodings of the control
// register, and the entry format held in the data write buffer
package crc_ahb_pkg;

	// Bus data word and running CRC value
	typedef logic [31:0] crc_word_t;

	// CRC width, only the low N bits of CRC, POL and INIT count
	typedef enum logic [1:0]
	{
		POLY_32 = 2'd0,
		POLY_16 = 2'd1,
		POLY_8  = 2'd2,
		POLY_7  = 2'd3
	} poly_size_t;

	// Bit reversal applied to data written to DR
	typedef enum logic [1:0]
	{
		REV_NONE = 2'd0,
		REV_BYTE = 2'd1,
		REV_HALF = 2'd2,
		REV_WORD = 2'd3
	} rev_in_t;

	// Low bits of HSIZE: 0 byte, 1 halfword, 2 word
	typedef logic [1:0] bus_size_t;

	// One pending DR write, 34 bits
	typedef struct packed
	{
		crc_word_t data;
		bus_size_t size;
	} buf_entry_t;

endpackage

// File: hdl/host_interface.sv
// AHB-Lite host interface of the CRC accelerator
// Captures the address phase, decodes per-register write enables,
// holds the control register, stretches HREADYOUT while the buffer,
// the engine or a pending chain reset cannot take the access, and
// muxes the register read data
`timescale 1ns/1ps

module host_interface
(
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  logic                   HSElx,
	input  logic [31:0]            HADDR,
	input  logic [1:0]             HTRANS,
	input  logic [2:0]             HSIZE,
	input  logic                   HWRITE,
	input  logic                   HREADY,
	input  crc_ahb_pkg::crc_word_t HWDATA,
	input  crc_ahb_pkg::crc_word_t crc_out,
	input  crc_ahb_pkg::crc_word_t crc_init_out,
	input  crc_ahb_pkg::crc_word_t crc_poly_out,
	input  logic [7:0]             crc_idr_out,
	input  logic                   buffer_full,
	input  logic                   read_wait,
	input  logic                   reset_pending,
	output crc_ahb_pkg::crc_word_t HRDATA,
	output logic                   HREADYOUT,
	output logic                   HRESP,
	output crc_ahb_pkg::crc_word_t bus_wr,
	output crc_ahb_pkg::bus_size_t bus_size,
	output logic                   buffer_write_en,
	output logic                   crc_init_en,
	output logic                   crc_poly_en,
	output logic                   crc_idr_en,
	output logic                   reset_chain,
	output crc_ahb_pkg::poly_size_t crc_poly_size,
	output crc_ahb_pkg::rev_in_t   rev_in_type,
	output logic                   rev_out_type
);
	import crc_ahb_pkg::*;
	`include "crc_ahb_cfg.svh"

	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	// Address phase flops
	logic [2:0] haddr_pp;
	bus_size_t  hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	// Control register {rev_out, rev_in, poly_size}
	logic [4:0] cr_ff;

	logic sample_bus;
	logic xfer_act;
	logic write_en;
	logic dr_read;
	logic init_wr;
	logic cr_en;
	logic any_en;

	////////////////////////////////////////////////////////////////////////////
	// Address phase capture
	////////////////////////////////////////////////////////////////////////////

	// Sampled only when the previous data phase completes
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= 2'b00;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	// Offset and size of the captured transfer
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	// SEQ and BUSY fall through like IDLE
	assign xfer_act = hselx_pp && (htrans_pp == HTRANS_NONSEQ);
	assign write_en = xfer_act && hwrite_pp;
	assign dr_read  = xfer_act && !hwrite_pp && (haddr_pp == `CRC_DR_OFS);
	assign init_wr  = write_en && (haddr_pp == `CRC_INIT_OFS);

	assign buffer_write_en = write_en && (haddr_pp == `CRC_DR_OFS);
	// INIT is held off until the engine has taken the old value
	assign crc_init_en     = init_wr && !reset_pending;
	assign crc_poly_en     = write_en && (haddr_pp == `CRC_POL_OFS);
	assign crc_idr_en      = write_en && (haddr_pp == `CRC_IDR_OFS);
	assign cr_en           = write_en && (haddr_pp == `CRC_CR_OFS);

	// HWDATA arrives in the data phase and passes straight through
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Wait states while a resource is not ready
	assign HREADYOUT = !((buffer_write_en && buffer_full) ||
	                     (dr_read && read_wait) ||
	                     (init_wr && reset_pending));

	// Never an error response
	assign HRESP = 1'b0;

	////////////////////////////////////////////////////////////////////////////
	// Control register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_ff <= `CRC_CR_RST;
		else if (cr_en)
			cr_ff <= HWDATA[7:3];
	end

	// Bit 0 is self clearing and only leaves this block as a pulse
	assign reset_chain   = cr_en && HWDATA[0];
	assign crc_poly_size = poly_size_t'(cr_ff[1:0]);
	assign rev_in_type   = rev_in_t'(cr_ff[3:2]);
	assign rev_out_type  = cr_ff[4];

	// Read data mux on the captured offset
	always_comb
	begin
		case (haddr_pp)
			`CRC_DR_OFS:   HRDATA = crc_out;
			`CRC_IDR_OFS:  HRDATA = {24'h0, crc_idr_out};
			`CRC_CR_OFS:   HRDATA = {24'h0, cr_ff, 3'b000};
			`CRC_INIT_OFS: HRDATA = crc_init_out;
			`CRC_POL_OFS:  HRDATA = crc_poly_out;
			default:       HRDATA = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////
	assign any_en = buffer_write_en || crc_init_en || crc_poly_en || crc_idr_en || reset_chain;

	// Enables only come from a NONSEQ write to this slave seen on the bus,
	// or from a data phase still held by a wait state
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		any_en |-> $past(!HREADYOUT ||
		                 (HREADY && HSElx && HWRITE && (HTRANS == HTRANS_NONSEQ))));

	// A DR read waits on the engine with its data phase held
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_read && read_wait) |-> !HREADYOUT ##1 dr_read);

endmodule

// File: hdl/crc_regs.sv
// CRC configuration registers
// INIT holds the value loaded on a chain reset, POL the generator
// polynomial used by the engine, IDR is a free 8-bit scratch byte
`timescale 1ns/1ps

module crc_regs
(
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  crc_ahb_pkg::crc_word_t bus_wr,
	input  logic                   crc_init_en,
	input  logic                   crc_poly_en,
	input  logic                   crc_idr_en,
	output crc_ahb_pkg::crc_word_t crc_init_out,
	output crc_ahb_pkg::crc_word_t crc_poly_out,
	output logic [7:0]             crc_idr_out
);
	import crc_ahb_pkg::*;
	`include "crc_ahb_cfg.svh"

	crc_word_t  init_ff;
	crc_word_t  poly_ff;
	logic [7:0] idr_ff;

	// Initial value, full word kept, width applied by the engine
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			init_ff <= `CRC_INIT_RST;
		else if (crc_init_en)
			init_ff <= bus_wr;
	end

	// Polynomial, implicit top term not stored
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			poly_ff <= `CRC_POL_RST;
		else if (crc_poly_en)
			poly_ff <= bus_wr;
	end

	// Scratch byte, upper bus bits dropped
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			idr_ff <= 8'h00;
		else if (crc_idr_en)
			idr_ff <= bus_wr[7:0];
	end

	assign crc_init_out = init_ff;
	assign crc_poly_out = poly_ff;
	assign crc_idr_out  = idr_ff;

	// Decode in the host interface selects a single register per access
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$onehot0({crc_init_en, crc_poly_en, crc_idr_en}));

endmodule

// File: hdl/input_buffer.sv
// Data write buffer
// Circular FIFO between the bus and the CRC engine, so DR writes
// complete without waiting on the byte-serial update
// Flush drops every queued entry in one cycle
`timescale 1ns/1ps

module input_buffer
#(
	parameter int DEPTH = 2
)
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic                    push,
	input  crc_ahb_pkg::buf_entry_t push_entry,
	input  logic                    pop,
	input  logic                    flush,
	output crc_ahb_pkg::buf_entry_t head_entry,
	output logic                    full,
	output logic                    empty
);
	import crc_ahb_pkg::*;

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	buf_entry_t mem [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Entry storage written on each accepted push
	always_ff @(posedge HCLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and fill level
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop keeps the level
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	assign full       = (count == CW'(DEPTH));
	assign empty      = (count == '0);
	assign head_entry = mem[rd_ptr];

	// Engine only pops what is queued
	assert property (@(posedge HCLK) disable iff (!HRESETn) pop |-> !empty);

	// Level stays within the storage and full never meets empty
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(full && empty) && (count <= CW'(DEPTH)));

endmodule

// File: hdl/crc_unit.sv
// Byte-serial CRC engine
// Pops one buffered DR write at a time, applies the input bit
// reversal, folds the valid bytes into the CRC one per cycle and
// presents the result with optional output reversal
// Also sequences the chain reset through flush, one pending cycle and reload
`timescale 1ns/1ps

module crc_unit
(
	input  logic                     HCLK,
	input  logic                     HRESETn,
	input  crc_ahb_pkg::buf_entry_t  head_entry,
	input  logic                     empty,
	input  logic                     reset_chain,
	input  crc_ahb_pkg::crc_word_t   crc_init_out,
	input  crc_ahb_pkg::crc_word_t   crc_poly_out,
	input  crc_ahb_pkg::poly_size_t  crc_poly_size,
	input  crc_ahb_pkg::rev_in_t     rev_in_type,
	input  logic                     rev_out_type,
	output logic                     pop,
	output logic                     flush,
	output crc_ahb_pkg::crc_word_t   crc_out,
	output logic                     read_wait,
	output logic                     reset_pending
);
	import crc_ahb_pkg::*;

	crc_word_t  crc_ff;
	crc_word_t  data_ff;
	logic [1:0] byte_cnt;
	logic       busy;

	crc_word_t  crc_mask;
	logic [4:0] crc_msb;
	logic [4:0] out_shift;
	crc_word_t  rev_data;
	crc_word_t  crc_bitrev;

	// Bit reversal of the written word per byte, per half or whole
	function automatic crc_word_t reverse_in(input crc_word_t d, input rev_in_t mode);
		crc_word_t r;
		int        i;
		r = d;
		for (i = 0; i < 32; i++)
		begin
			case (mode)
				REV_BYTE: r[i] = d[(i / 8) * 8 + 7 - (i % 8)];
				REV_HALF: r[i] = d[(i / 16) * 16 + 15 - (i % 16)];
				REV_WORD: r[i] = d[31 - i];
				default:  r[i] = d[i];
			endcase
		end
		return r;
	endfunction

	// Eight shift steps with the data MSB first
	function automatic crc_word_t crc_byte(input crc_word_t crc, input logic [7:0] din,
	                                       input crc_word_t poly, input crc_word_t mask,
	                                       input logic [4:0] msb);
		crc_word_t c;
		logic      fb;
		int        i;
		c = crc;
		for (i = 7; i >= 0; i--)
		begin
			fb = c[msb] ^ din[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Width dependent constants
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (crc_poly_size)
			POLY_16:
			begin
				crc_mask  = 32'h0000_FFFF;
				crc_msb   = 5'd15;
				out_shift = 5'd16;
			end
			POLY_8:
			begin
				crc_mask  = 32'h0000_00FF;
				crc_msb   = 5'd7;
				out_shift = 5'd24;
			end
			POLY_7:
			begin
				crc_mask  = 32'h0000_007F;
				crc_msb   = 5'd6;
				out_shift = 5'd25;
			end
			default:
			begin
				crc_mask  = 32'hFFFF_FFFF;
				crc_msb   = 5'd31;
				out_shift = 5'd0;
			end
		endcase
	end

	assign rev_data = reverse_in(head_entry.data, rev_in_type);

	// Take a new entry only when idle and no chain reset is in flight
	assign pop       = !busy && !empty && !reset_chain && !reset_pending;
	assign flush     = reset_chain;
	// Pending reload also holds DR reads off
	assign read_wait = busy || !empty || reset_pending;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer and CRC register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			busy          <= 1'b0;
			byte_cnt      <= 2'd0;
			reset_pending <= 1'b0;
			// CRC follows INIT out of reset one edge later
			crc_ff        <= crc_init_out;
		end
		else if (reset_chain)
		begin
			// Abandon the entry in progress
			busy          <= 1'b0;
			reset_pending <= 1'b1;
		end
		else if (reset_pending)
		begin
			reset_pending <= 1'b0;
			crc_ff        <= crc_init_out & crc_mask;
		end
		else if (pop)
		begin
			busy <= 1'b1;
			case (head_entry.size)
				2'd0:    byte_cnt <= 2'd0;
				2'd1:    byte_cnt <= 2'd1;
				default: byte_cnt <= 2'd3;
			endcase
		end
		else if (busy)
		begin
			crc_ff <= crc_byte(crc_ff, data_ff[31:24], crc_poly_out, crc_mask, crc_msb);
			if (byte_cnt == 2'd0)
				busy <= 1'b0;
			else
				byte_cnt <= byte_cnt - 1'b1;
		end
	end

	// Valid bytes left aligned so the top byte is always next
	always_ff @(posedge HCLK)
	begin
		if (pop)
		begin
			case (head_entry.size)
				2'd0:    data_ff <= rev_data << 24;
				2'd1:    data_ff <= rev_data << 16;
				default: data_ff <= rev_data;
			endcase
		end
		else if (busy)
			data_ff <= data_ff << 8;
	end

	// Output reversal over N bits with zeros above
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			crc_bitrev[i] = crc_ff[31 - i];
	end

	assign crc_out = rev_out_type ? ((crc_bitrev & ~(crc_mask ^ 32'hFFFF_FFFF) << out_shift)
	                                 >> out_shift)
	                              : (crc_ff & crc_mask);

	// A busy period never outlasts the four bytes of a word
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(busy && $past(busy) && $past(busy, 2) && $past(busy, 3)) |=> !busy);

endmodule

// File: hdl/crc_ahb.sv
// CRC accelerator, AHB-Lite slave top level
// Host interface, configuration registers, data write buffer and
// byte-serial CRC engine tied to the AHB slave ports
`timescale 1ns/1ps

module crc_ahb
(
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  logic                   HSElx,
	input  logic [31:0]            HADDR,
	input  logic [1:0]             HTRANS,
	input  logic [2:0]             HSIZE,
	input  logic                   HWRITE,
	input  logic                   HREADY,
	input  crc_ahb_pkg::crc_word_t HWDATA,
	output crc_ahb_pkg::crc_word_t HRDATA,
	output logic                   HREADYOUT,
	output logic                   HRESP
);
	import crc_ahb_pkg::*;
	`include "crc_ahb_cfg.svh"

	// Bus side
	crc_word_t  bus_wr;
	bus_size_t  bus_size;
	logic       buffer_write_en;
	logic       crc_init_en;
	logic       crc_poly_en;
	logic       crc_idr_en;
	logic       reset_chain;

	// Configuration
	poly_size_t crc_poly_size;
	rev_in_t    rev_in_type;
	logic       rev_out_type;
	crc_word_t  crc_init_out;
	crc_word_t  crc_poly_out;
	logic [7:0] crc_idr_out;

	// Buffer and engine
	buf_entry_t push_entry;
	buf_entry_t head_entry;
	logic       buffer_full;
	logic       buffer_empty;
	logic       pop;
	logic       flush;
	crc_word_t  crc_out;
	logic       read_wait;
	logic       reset_pending;

	assign push_entry = '{data: bus_wr, size: bus_size};

	host_interface u_host (.*, .buffer_full(buffer_full));

	crc_regs u_regs (.*);

	input_buffer #(.DEPTH(`CRC_BUF_DEPTH)) u_buf
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.push       (buffer_write_en),
		.push_entry (push_entry),
		.pop        (pop),
		.flush      (flush),
		.head_entry (head_entry),
		.full       (buffer_full),
		.empty      (buffer_empty)
	);

	crc_unit u_crc (.*, .empty(buffer_empty));

endmodule

// File: sim/tb_crc_ahb.sv
// Testbench for the AHB-Lite CRC accelerator
// Random NONSEQ master with idle gaps, bit-level CRC reference model,
// register read-back, ignored transfers and a watchdog on the run
`timescale 1ns/1ps

module tb_crc_ahb;
	import crc_ahb_pkg::*;
	`include "crc_ahb_cfg.svh"

	localparam int CLK_PERIOD = 100;
	localparam int RB_LOOPS   = 8;
	localparam int N_DATA     = 20;
	// Reset reads, read-back, eight CRC runs, ignored transfers
	localparam int N_XFERS     = 5 + RB_LOOPS * 8 + 8 * (N_DATA + 7) + 18;
	localparam int WATCHDOG_NS = (N_XFERS * 40 + 24) * CLK_PERIOD;

	localparam logic [1:0] T_IDLE   = 2'b00;
	localparam logic [1:0] T_NONSEQ = 2'b10;
	localparam logic [1:0] T_SEQ    = 2'b11;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic        HREADY;
	crc_word_t   HWDATA;
	crc_word_t   HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	integer seed;
	int     err_cnt;

	// Reference model state
	crc_word_t  m_crc;
	crc_word_t  m_init;
	crc_word_t  m_poly;
	logic [1:0] m_psize;
	logic [1:0] m_rev_in;
	logic       m_rev_out;
	logic [7:0] m_idr;
	logic [7:0] m_cr;

	crc_ahb UUT
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HREADY    (HREADY),
		.HWDATA    (HWDATA),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	// Single slave on the bus
	assign HREADY = HREADYOUT;

	initial
	begin
		HCLK = 1'b0;
		forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic crc_word_t width_mask(input logic [1:0] psize);
		case (psize)
			2'd1:    return 32'h0000_FFFF;
			2'd2:    return 32'h0000_00FF;
			2'd3:    return 32'h0000_007F;
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	function automatic int width_bits(input logic [1:0] psize);
		case (psize)
			2'd1:    return 16;
			2'd2:    return 8;
			2'd3:    return 7;
			default: return 32;
		endcase
	endfunction

	// Mirror of the low n bits, zero above
	function automatic crc_word_t bit_rev_n(input crc_word_t v, input int n);
		crc_word_t r;
		crc_word_t t;
		int        i;
		r = '0;
		t = v;
		for (i = 0; i < n; i++)
		begin
			r = (r << 1) | (t & 32'h1);
			t = t >> 1;
		end
		return r;
	endfunction

	// Input reversal per byte, per halfword or over the word
	function automatic crc_word_t rev_data(input crc_word_t d, input logic [1:0] mode);
		crc_word_t r;
		int        b;
		r = '0;
		case (mode)
			2'd1:
				for (b = 0; b < 4; b++)
					r = r | (bit_rev_n((d >> (8 * b)) & 32'hFF, 8) << (8 * b));
			2'd2:
				for (b = 0; b < 2; b++)
					r = r | (bit_rev_n((d >> (16 * b)) & 32'hFFFF, 16) << (16 * b));
			2'd3:    r = bit_rev_n(d, 32);
			default: r = d;
		endcase
		return r;
	endfunction

	// Fold one DR write into the model CRC, top valid byte first
	task automatic model_push(input logic [2:0] size, input crc_word_t d);
		crc_word_t  rd;
		crc_word_t  mask;
		crc_word_t  topbit;
		logic [7:0] byt;
		logic       fb;
		int         nbytes;
		int         b;
		int         i;
		rd     = rev_data(d, m_rev_in);
		mask   = width_mask(m_psize);
		topbit = 32'h1 << (width_bits(m_psize) - 1);
		nbytes = (size == 3'd0) ? 1 : (size == 3'd1) ? 2 : 4;
		for (b = nbytes - 1; b >= 0; b--)
		begin
			byt = 8'(rd >> (8 * b));
			for (i = 0; i < 8; i++)
			begin
				fb    = ((m_crc & topbit) != 0) ^ byt[7];
				byt   = byt << 1;
				m_crc = (m_crc << 1) & mask;
				if (fb)
					m_crc = m_crc ^ (m_poly & mask);
			end
		end
	endtask

	// DR read value, N-bit mirror when output reversal is on
	function automatic crc_word_t expected_dr();
		crc_word_t c;
		c = m_crc & width_mask(m_psize);
		return m_rev_out ? bit_rev_n(c, width_bits(m_psize)) : c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and bus master
	////////////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input crc_word_t exp, input crc_word_t act);
		if (exp !== act)
		begin
			err_cnt++;
			$display("[FAIL] %s expected 0x%08h got 0x%08h", name, exp, act);
			$display("tests failed");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// Outputs come from flops only, so the falling edge sees the
	// values of the coming rising edge
	task automatic wait_ready(output crc_word_t rdata);
		logic rdy;
		rdy   = 1'b0;
		rdata = '0;
		while (!rdy)
		begin
			@(negedge HCLK);
			rdy   = HREADYOUT;
			rdata = HRDATA;
			check_value("HRESP", 32'h0, {31'h0, HRESP});
			@(posedge HCLK);
			#1;
		end
	endtask

	// Address phase, data phase, then a random idle gap
	task automatic bus_xfer(input logic sel, input logic [1:0] trans, input logic wr,
	                        input logic [2:0] ofs, input logic [2:0] size,
	                        input crc_word_t wdata, output crc_word_t rdata);
		crc_word_t addr_rd;
		int        gap;
		HSElx  = sel;
		HTRANS = trans;
		HWRITE = wr;
		HADDR  = {27'h0, ofs, 2'b00};
		HSIZE  = size;
		wait_ready(addr_rd);
		HSElx  = 1'b0;
		HTRANS = T_IDLE;
		HWRITE = 1'b0;
		HWDATA = wdata;
		wait_ready(rdata);
		gap = $random(seed);
		repeat (gap & 3)
		begin
			@(posedge HCLK);
			#1;
		end
	endtask

	task automatic write_reg(input logic [2:0] ofs, input logic [2:0] size, input crc_word_t d);
		crc_word_t unused_rd;
		bus_xfer(1'b1, T_NONSEQ, 1'b1, ofs, size, d, unused_rd);
	endtask

	task automatic read_check(input logic [2:0] ofs, input string name, input crc_word_t exp);
		crc_word_t rd;
		bus_xfer(1'b1, T_NONSEQ, 1'b0, ofs, 3'd2, 32'h0, rd);
		check_value(name, exp, rd);
	endtask

	// Registers seen by the master, compared against the model
	task automatic read_all_regs();
		read_check(`CRC_IDR_OFS, "HRDATA(IDR)", {24'h0, m_idr});
		read_check(`CRC_INIT_OFS, "HRDATA(INIT)", m_init);
		read_check(`CRC_POL_OFS, "HRDATA(POL)", m_poly);
		read_check(`CRC_CR_OFS, "HRDATA(CR)", {24'h0, m_cr});
	endtask

	// Program a random width, stream data, then chain reset to a new INIT
	task automatic crc_run(input logic [1:0] rin, input logic rout);
		crc_word_t  r;
		crc_word_t  d;
		logic [1:0] ps;
		logic [2:0] sz;
		int         k;
		r         = $random(seed);
		ps        = r[1:0];
		m_psize   = ps;
		m_rev_in  = rin;
		m_rev_out = rout;
		m_cr      = {rout, rin, ps, 3'b000};
		m_poly    = $random(seed);
		m_poly    = m_poly | 32'h1;
		m_init    = $random(seed);
		write_reg(`CRC_POL_OFS, 3'd2, m_poly);
		write_reg(`CRC_INIT_OFS, 3'd2, m_init);
		write_reg(`CRC_CR_OFS, 3'd2, {24'h0, m_cr | 8'h01});
		m_crc = m_init & width_mask(ps);
		for (k = 0; k < N_DATA; k++)
		begin
			r  = $random(seed);
			sz = (r[1:0] == 2'd3) ? 3'd2 : {1'b0, r[1:0]};
			d  = $random(seed);
			write_reg(`CRC_DR_OFS, sz, d);
			model_push(sz, d);
		end
		read_check(`CRC_DR_OFS, "HRDATA(DR)", expected_dr());
		// New INIT, then reload through CR bit 0
		m_init = $random(seed);
		write_reg(`CRC_INIT_OFS, 3'd2, m_init);
		write_reg(`CRC_CR_OFS, 3'd2, {24'h0, m_cr | 8'h01});
		m_crc = m_init & width_mask(ps);
		read_check(`CRC_DR_OFS, "HRDATA(DR)", expected_dr());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		crc_word_t  r;
		crc_word_t  unused_rd;
		logic [1:0] mode_trans;
		logic       mode_sel;
		int         n;
		int         rin;
		seed      = 97;
		err_cnt   = 0;
		HRESETn   = 1'b0;
		HSElx     = 1'b0;
		HADDR     = '0;
		HTRANS    = T_IDLE;
		HSIZE     = 3'd0;
		HWRITE    = 1'b0;
		HWDATA    = '0;
		m_init    = `CRC_INIT_RST;
		m_poly    = `CRC_POL_RST;
		m_crc     = `CRC_INIT_RST;
		m_psize   = 2'd0;
		m_rev_in  = 2'd0;
		m_rev_out = 1'b0;
		m_idr     = 8'h00;
		m_cr      = {`CRC_CR_RST, 3'b000};
		repeat (16) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;
		@(posedge HCLK);
		#1;

		// Reset values
		read_all_regs();
		read_check(`CRC_DR_OFS, "HRDATA(DR)", `CRC_INIT_RST);

		// Read-back, CR bit 0 kept clear so the CRC is untouched
		for (n = 0; n < RB_LOOPS; n++)
		begin
			r     = $random(seed);
			m_idr = r[7:0];
			write_reg(`CRC_IDR_OFS, 3'd2, r);
			m_init = $random(seed);
			write_reg(`CRC_INIT_OFS, 3'd2, m_init);
			m_poly = $random(seed);
			write_reg(`CRC_POL_OFS, 3'd2, m_poly);
			r    = $random(seed);
			m_cr = {r[7:3], 3'b000};
			write_reg(`CRC_CR_OFS, 3'd2, r & 32'hFFFF_FFFE);
			read_all_regs();
		end

		// Every input reversal with both output options
		for (rin = 0; rin < 4; rin++)
		begin
			crc_run(2'(rin), 1'b0);
			crc_run(2'(rin), 1'b1);
		end

		// Deselected, IDLE and SEQ transfers must leave all registers
		for (n = 0; n < 3; n++)
		begin
			mode_sel   = (n != 0);
			mode_trans = (n == 1) ? T_IDLE : (n == 2) ? T_SEQ : T_NONSEQ;
			bus_xfer(mode_sel, mode_trans, 1'b1, `CRC_IDR_OFS, 3'd2, ~m_idr, unused_rd);
			bus_xfer(mode_sel, mode_trans, 1'b1, `CRC_INIT_OFS, 3'd2, ~m_init, unused_rd);
			bus_xfer(mode_sel, mode_trans, 1'b1, `CRC_POL_OFS, 3'd2, ~m_poly, unused_rd);
			bus_xfer(mode_sel, mode_trans, 1'b1, `CRC_CR_OFS, 3'd2, 32'hFF, unused_rd);
		end
		bus_xfer(1'b0, T_NONSEQ, 1'b1, `CRC_DR_OFS, 3'd2, 32'h1234_5678, unused_rd);
		read_all_regs();
		read_check(`CRC_DR_OFS, "HRDATA(DR)", expected_dr());

		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Bound on the whole run, sized from the planned transfer count
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the bus hung waiting for HREADYOUT");
		$display("tests failed");
		$fatal(1, "Timeout");
	end

endmodule

// File: flist.f
+incdir+hdl
hdl/crc_ahb_pkg.sv
hdl/host_interface.sv
hdl/crc_regs.sv
hdl/input_buffer.sv
hdl/crc_unit.sv
hdl/crc_ahb.sv
sim/tb_crc_ahb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_crc_ahb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
